//--- aluPkg.sv
// aluPkg
// shared types and constants for the ALU execute subsystem
// opcode and condition encodings, flag layout, instruction word, APB map
`default_nettype none

package aluPkg;

    // operation encodings, 1100 to 1111 reserved for memory ops
    typedef enum logic [3:0] {
        ADD  = 4'b0000,
        SUB  = 4'b0001,
        MUL  = 4'b0010,
        OR   = 4'b0011,
        AND  = 4'b0100,
        XOR  = 4'b0101,
        MOVI = 4'b0110,
        MOV  = 4'b0111,
        LSR  = 4'b1000,
        LSL  = 4'b1001,
        ROR  = 4'b1010,
        CMP  = 4'b1011
    } opcodeE;

    // condition field, unlisted values never execute
    typedef enum logic [3:0] {
        AL = 4'b0000,
        EQ = 4'b0001,
        GT = 4'b0010,
        LT = 4'b0011,
        GE = 4'b0100,
        LE = 4'b0101,
        HI = 4'b0110,
        CC = 4'b0111,
        CS = 4'b1000
    } condE;

    // status flags, n in bit 3 down to v in bit 0
    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flagsT;

    // instruction word as pushed by the host
    // MOVI takes its immediate from bits 15..0, over rm and setFlags
    typedef struct packed {
        condE       cond;
        opcodeE     opcode;
        logic [3:0] rd;
        logic [3:0] rn;
        logic [3:0] rm;
        logic       setFlags;
        logic [5:0] spare;
        logic [4:0] shamt;
    } issueOpT;

    // APB byte addresses
    localparam logic [7:0] ADDR_INSTR    = 8'h00;
    localparam logic [7:0] ADDR_STATUS   = 8'h04;
    localparam logic [7:0] ADDR_FLAGS    = 8'h08;
    localparam logic [7:0] ADDR_RETIRED  = 8'h0C;
    // register i lives at base + 4*i
    localparam logic [7:0] ADDR_REG_BASE = 8'h40;

endpackage

`default_nettype wire

//--- regAccessIf.sv
// regAccessIf
// one register write port plus two read ports into the register file
`default_nettype none

interface regAccessIf;
    // read side
    logic [3:0]  raddrA;
    logic [3:0]  raddrB;
    logic [31:0] rdataA;
    logic [31:0] rdataB;
    // write side
    logic        we;
    logic [3:0]  waddr;
    logic [31:0] wdata;

    // register file side
    modport owner (input raddrA, raddrB, we, waddr, wdata, output rdataA, rdataB);
    // requester side
    modport user (output raddrA, raddrB, we, waddr, wdata, input rdataA, rdataB);
endinterface

`default_nettype wire

//--- apbIssue.sv
// apbIssue
// APB slave front end of the execute subsystem
// pushes instruction words into the FIFO, applies host register and flag
// writes once the FIFO has drained, and muxes read data
`default_nettype none

module apbIssue #(
    parameter int DEPTH = 4
) (
    input  wire logic                         clk,
    input  wire logic                         rstN,
    input  wire logic                         PSEL,
    input  wire logic                         PENABLE,
    input  wire logic                         PWRITE,
    input  wire logic [7:0]                   PADDR,
    input  wire logic [31:0]                  PWDATA,
    output logic      [31:0]                  PRDATA,
    output logic                              PREADY,
    output logic                              PSLVERR,
    output logic                              pushValid,
    input  wire logic                         pushReady,
    output aluPkg::issueOpT                   pushData,
    input  wire logic [$clog2(DEPTH+1)-1:0]   fifoCount,
    input  wire logic                         fifoEmpty,
    input  aluPkg::flagsT                     flagsIn,
    output logic                              flagsWe,
    output aluPkg::flagsT                     flagsWdata,
    input  wire logic [31:0]                  retired,
    regAccessIf.user                          hostRegs
);

    logic       setupDone;
    logic       access;
    logic       wrAccess;
    logic       isInstr;
    logic       isStatus;
    logic       isFlags;
    logic       isRetired;
    logic       isReg;
    logic [3:0] regIdx;

    // address decode
    assign isInstr   = (PADDR == aluPkg::ADDR_INSTR);
    assign isStatus  = (PADDR == aluPkg::ADDR_STATUS);
    assign isFlags   = (PADDR == aluPkg::ADDR_FLAGS);
    assign isRetired = (PADDR == aluPkg::ADDR_RETIRED);
    // 0x40..0x7C, word aligned
    assign isReg     = (PADDR[7:6] == aluPkg::ADDR_REG_BASE[7:6]) && (PADDR[1:0] == 2'b00);
    assign regIdx    = PADDR[5:2];

    // access phase only counts after a proper setup cycle
    always_ff @(posedge clk)
    begin
        if (!rstN)
            setupDone <= 1'b0;
        else if (PSEL && !PENABLE)
            setupDone <= 1'b1;
        else if (access && PREADY)
            setupDone <= 1'b0;
    end

    assign access   = PSEL && PENABLE && setupDone;
    assign wrAccess = access && PWRITE;

    // wait states: instr waits for space, flag and reg writes wait for drain
    always_comb
    begin
        PREADY = 1'b1;
        if (PSEL && PWRITE)
        begin
            if (isInstr && !pushReady)
                PREADY = 1'b0;
            else if ((isFlags || isReg) && !fifoEmpty)
                PREADY = 1'b0;
        end
    end

    // no error responses
    assign PSLVERR = 1'b0;

    // instruction push, handshake completes together with the APB transfer
    assign pushValid = wrAccess && isInstr;
    assign pushData  = aluPkg::issueOpT'(PWDATA);

    // host flag write
    assign flagsWe    = wrAccess && isFlags && fifoEmpty;
    assign flagsWdata = aluPkg::flagsT'(PWDATA[3:0]);

    // host register port
    assign hostRegs.raddrA = regIdx;
    assign hostRegs.we     = wrAccess && isReg && fifoEmpty;
    assign hostRegs.waddr  = regIdx;
    assign hostRegs.wdata  = PWDATA;

    // read mux, combinational in the access cycle
    always_comb
    begin
        PRDATA = '0;
        if (isStatus)
            PRDATA[7:0] = 8'(fifoCount);
        else if (isFlags)
            PRDATA[3:0] = flagsIn;
        else if (isRetired)
            PRDATA = retired;
        else if (isReg)
            PRDATA = hostRegs.rdataA;
    end

endmodule

`default_nettype wire

//--- opFifo.sv
// opFifo
// synchronous circular FIFO with a combinational head entry
// push and pop may happen in the same cycle
`default_nettype none

module opFifo #(
    parameter int  DEPTH    = 4,
    parameter type payloadT = logic [31:0]
) (
    input  wire logic                       clk,
    input  wire logic                       rstN,
    input  wire logic                       pushValid,
    output logic                            pushReady,
    input  payloadT                         pushData,
    output logic                            popValid,
    input  wire logic                       popReady,
    output payloadT                         popData,
    output logic [$clog2(DEPTH+1)-1:0]      count,
    output logic                            empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payloadT          mem [DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic             doPush;
    logic             doPop;

    assign doPush = pushValid && pushReady;
    assign doPop  = popValid && popReady;

    // entry storage
    always_ff @(posedge clk)
    begin
        if (doPush)
            mem[wrPtr] <= pushData;
    end

    // pointers wrap at DEPTH so any depth works
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (doPush)
                wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            if (doPop)
                rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            // simultaneous push and pop leaves count alone
            if (doPush && !doPop)
                count <= count + 1'b1;
            else if (doPop && !doPush)
                count <= count - 1'b1;
        end
    end

    assign empty     = (count == '0);
    assign pushReady = (count != ($clog2(DEPTH+1))'(DEPTH));
    assign popValid  = !empty;
    assign popData   = mem[rdPtr];

endmodule

`default_nettype wire

//--- regFile.sv
// regFile
// sixteen 32-bit general registers
// exec side has two reads and the priority write, host side one of each
`default_nettype none

module regFile (
    input  wire logic clk,
    input  wire logic rstN,
    regAccessIf.owner execRegs,
    regAccessIf.owner hostRegs
);

    logic [31:0] regs [16];

    // exec write wins, host only writes while the FIFO is empty anyway
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < 16; i++)
                regs[i] <= '0;
        end
        else if (execRegs.we)
            regs[execRegs.waddr] <= execRegs.wdata;
        else if (hostRegs.we)
            regs[hostRegs.waddr] <= hostRegs.wdata;
    end

    // operand reads for the ALU
    assign execRegs.rdataA = regs[execRegs.raddrA];
    assign execRegs.rdataB = regs[execRegs.raddrB];
    // host readback
    assign hostRegs.rdataA = regs[hostRegs.raddrA];

endmodule

`default_nettype wire

//--- aluCore.sv
// aluCore
// combinational ALU: result, updated flags and rd write enable per opcode
`default_nettype none

module aluCore (
    input  aluPkg::opcodeE   opcode,
    input  wire logic [31:0] rnVal,
    input  wire logic [31:0] rmVal,
    input  wire logic [15:0] imm16,
    input  wire logic [4:0]  shamt,
    input  aluPkg::flagsT    flagsIn,
    output logic [31:0]      result,
    output aluPkg::flagsT    flagsOut,
    output logic             writesRd
);

    logic [32:0] sum;
    logic [32:0] diff;
    logic        addOvf;
    logic        subOvf;
    logic [32:0] lsrWide;
    logic [32:0] lslWide;
    logic [63:0] rorWide;
    logic        setNz;

    // carry out in bit 32
    assign sum  = {1'b0, rnVal} + {1'b0, rmVal};
    // bit 32 is the borrow
    assign diff = {1'b0, rnVal} - {1'b0, rmVal};

    // same sign in, other sign out
    assign addOvf = (rnVal[31] == rmVal[31]) && (sum[31] != rnVal[31]);
    // signs differ and result flips away from rn
    assign subOvf = (rnVal[31] != rmVal[31]) && (diff[31] != rnVal[31]);

    // extra bit below catches the last bit shifted out right
    assign lsrWide = {rmVal, 1'b0} >> shamt;
    // extra bit above catches the last bit shifted out left
    assign lslWide = {1'b0, rmVal} << shamt;
    assign rorWide = {rmVal, rmVal} >> shamt;

    always_comb
    begin
        result   = '0;
        flagsOut = flagsIn;
        writesRd = 1'b1;
        setNz    = 1'b1;
        case (opcode)
            aluPkg::ADD:
            begin
                result     = sum[31:0];
                flagsOut.c = sum[32];
                flagsOut.v = addOvf;
            end
            aluPkg::SUB, aluPkg::CMP:
            begin
                result     = diff[31:0];
                // no borrow means rn >= rm
                flagsOut.c = !diff[32];
                flagsOut.v = subOvf;
                writesRd   = (opcode != aluPkg::CMP);
            end
            aluPkg::MUL:
                result = rnVal * rmVal;
            aluPkg::OR:
                result = rnVal | rmVal;
            aluPkg::AND:
                result = rnVal & rmVal;
            aluPkg::XOR:
                result = rnVal ^ rmVal;
            aluPkg::MOVI:
            begin
                result = {16'h0000, imm16};
                setNz  = 1'b0;
            end
            aluPkg::MOV:
            begin
                result = rmVal;
                setNz  = 1'b0;
            end
            aluPkg::LSR:
            begin
                result = lsrWide[32:1];
                if (shamt != '0)
                    flagsOut.c = lsrWide[0];
            end
            aluPkg::LSL:
            begin
                result = lslWide[31:0];
                if (shamt != '0)
                    flagsOut.c = lslWide[32];
            end
            aluPkg::ROR:
            begin
                result = rorWide[31:0];
                if (shamt != '0)
                    flagsOut.c = rorWide[31];
            end
            // reserved memory ops, nothing changes
            default:
            begin
                writesRd = 1'b0;
                setNz    = 1'b0;
            end
        endcase
        if (setNz)
        begin
            flagsOut.n = result[31];
            flagsOut.z = (result == '0);
        end
    end

endmodule

`default_nettype wire

//--- execUnit.sv
// execUnit
// FIFO consumer: condition check, ALU, register writeback, flags register
// and retired instruction count
`default_nettype none

module execUnit (
    input  wire logic             clk,
    input  wire logic             rstN,
    input  wire logic             popValid,
    output logic                  popReady,
    input  aluPkg::issueOpT       popData,
    regAccessIf.user              execRegs,
    input  wire logic             flagsWe,
    input  aluPkg::flagsT         flagsWdata,
    output aluPkg::flagsT         flags,
    output logic [31:0]           retired
);

    logic          condPass;
    logic          reserved;
    logic          fire;
    logic [31:0]   aluResult;
    aluPkg::flagsT aluFlags;
    logic          writesRd;

    // one instruction per cycle, head is always consumed
    assign popReady = popValid;

    // operands straight from the head entry
    assign execRegs.raddrA = popData.rn;
    assign execRegs.raddrB = popData.rm;

    aluCore u_aluCore (
        .opcode   (popData.opcode),
        .rnVal    (execRegs.rdataA),
        .rmVal    (execRegs.rdataB),
        .imm16    (popData[15:0]),
        .shamt    (popData.shamt),
        .flagsIn  (flags),
        .result   (aluResult),
        .flagsOut (aluFlags),
        .writesRd (writesRd)
    );

    // condition against the current flags
    always_comb
    begin
        case (popData.cond)
            aluPkg::AL: condPass = 1'b1;
            aluPkg::EQ: condPass = flags.z;
            aluPkg::GT: condPass = !flags.z && (flags.n == flags.v);
            aluPkg::LT: condPass = (flags.n != flags.v);
            aluPkg::GE: condPass = (flags.n == flags.v);
            aluPkg::LE: condPass = flags.z || (flags.n != flags.v);
            aluPkg::HI: condPass = flags.c && !flags.z;
            aluPkg::CC: condPass = !flags.c;
            aluPkg::CS: condPass = flags.c;
            default:    condPass = 1'b0;
        endcase
    end

    // 11xx opcodes are the memory group
    assign reserved = (popData.opcode[3:2] == 2'b11);
    assign fire     = popValid && condPass;

    // writeback
    assign execRegs.we    = fire && writesRd;
    assign execRegs.waddr = popData.rd;
    assign execRegs.wdata = aluResult;

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            flags   <= '0;
            retired <= '0;
        end
        else
        begin
            // host writes only land with the FIFO empty
            if (flagsWe)
                flags <= flagsWdata;
            // CMP always updates flags
            if (fire && (popData.setFlags || popData.opcode == aluPkg::CMP))
                flags <= aluFlags;
            if (fire && !reserved)
                retired <= retired + 32'd1;
        end
    end

endmodule

`default_nettype wire

//--- aluExecTop.sv
// aluExecTop
// execute subsystem behind an APB slave port
// APB front end feeds an instruction FIFO drained by the execute stage
`default_nettype none

module aluExecTop #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic        clk,
    input  wire logic        rstN,
    input  wire logic        PSEL,
    input  wire logic        PENABLE,
    input  wire logic        PWRITE,
    input  wire logic [7:0]  PADDR,
    input  wire logic [31:0] PWDATA,
    output logic      [31:0] PRDATA,
    output logic             PREADY,
    output logic             PSLVERR
);

    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    // producer to FIFO
    logic            pushValid;
    logic            pushReady;
    aluPkg::issueOpT pushData;
    // FIFO to consumer
    logic            popValid;
    logic            popReady;
    aluPkg::issueOpT popData;
    logic [CNT_W-1:0] fifoCount;
    logic            fifoEmpty;
    // flags and counters
    aluPkg::flagsT   flags;
    aluPkg::flagsT   flagsWdata;
    logic            flagsWe;
    logic [31:0]     retired;

    regAccessIf execRegs ();
    regAccessIf hostRegs ();

    apbIssue #(
        .DEPTH (FIFO_DEPTH)
    ) u_apbIssue (
        .clk        (clk),
        .rstN       (rstN),
        .PSEL       (PSEL),
        .PENABLE    (PENABLE),
        .PWRITE     (PWRITE),
        .PADDR      (PADDR),
        .PWDATA     (PWDATA),
        .PRDATA     (PRDATA),
        .PREADY     (PREADY),
        .PSLVERR    (PSLVERR),
        .pushValid  (pushValid),
        .pushReady  (pushReady),
        .pushData   (pushData),
        .fifoCount  (fifoCount),
        .fifoEmpty  (fifoEmpty),
        .flagsIn    (flags),
        .flagsWe    (flagsWe),
        .flagsWdata (flagsWdata),
        .retired    (retired),
        .hostRegs   (hostRegs.user)
    );

    opFifo #(
        .DEPTH    (FIFO_DEPTH),
        .payloadT (aluPkg::issueOpT)
    ) u_opFifo (
        .clk       (clk),
        .rstN      (rstN),
        .pushValid (pushValid),
        .pushReady (pushReady),
        .pushData  (pushData),
        .popValid  (popValid),
        .popReady  (popReady),
        .popData   (popData),
        .count     (fifoCount),
        .empty     (fifoEmpty)
    );

    regFile u_regFile (
        .clk      (clk),
        .rstN     (rstN),
        .execRegs (execRegs.owner),
        .hostRegs (hostRegs.owner)
    );

    execUnit u_execUnit (
        .clk        (clk),
        .rstN       (rstN),
        .popValid   (popValid),
        .popReady   (popReady),
        .popData    (popData),
        .execRegs   (execRegs.user),
        .flagsWe    (flagsWe),
        .flagsWdata (flagsWdata),
        .flags      (flags),
        .retired    (retired)
    );

endmodule

`default_nettype wire

//--- aluExecTop_props.sv
// opFifoProps
// handshake and occupancy checks bound onto every opFifo instance
`default_nettype none

module opFifoProps #(
    parameter int DEPTH = 4
) (
    input wire logic                         clk,
    input wire logic                         rstN,
    input wire logic                         pushValid,
    input wire logic                         pushReady,
    input wire logic                         popValid,
    input wire logic                         popReady,
    input wire logic [$clog2(DEPTH+1)-1:0]   count
);
    timeunit 1ns;
    timeprecision 100ps;

    // a full FIFO stays full unless the head is popped
    pushWhenFull: assert property (@(posedge clk) disable iff (!rstN)
        (count == DEPTH && !(popValid && popReady)) |=> (count == DEPTH))
        else $error("push accepted while the FIFO is full");

    // an empty FIFO stays empty unless something is pushed
    popWhenEmpty: assert property (@(posedge clk) disable iff (!rstN)
        (count == 0 && !(pushValid && pushReady)) |=> (count == 0))
        else $error("pop taken while the FIFO is empty");

    // occupancy bound
    countInRange: assert property (@(posedge clk) disable iff (!rstN)
        count <= DEPTH)
        else $error("FIFO count is above its depth");

endmodule

bind opFifo opFifoProps #(
    .DEPTH (DEPTH)
) u_opFifoProps (
    .clk       (clk),
    .rstN      (rstN),
    .pushValid (pushValid),
    .pushReady (pushReady),
    .popValid  (popValid),
    .popReady  (popReady),
    .count     (count)
);

`default_nettype wire

//--- aluExecTb.sv
// aluExecTb
// testbench for the APB execute subsystem
// drives LFSR driven instruction streams and checks registers, flags and
// the retire count against a behavioral model
`default_nettype none

module aluExecTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int DEPTH      = 4;
    localparam int NUM_RANDOM = 48;
    localparam int NUM_COND   = 32;
    localparam int BURST_LEN  = 10;
    localparam int MAX_POLLS  = 20;
    // transfers per group padded for status polls
    localparam int XFERS = 20 + NUM_RANDOM * 10 + NUM_COND * 10
                         + BURST_LEN + 30 + DEPTH + 30 + 4 * 24;
    // a transfer takes two cycles plus a wait state at most
    localparam int CYCLE_LIMIT = 8 + 4 * XFERS;

    logic        clk;
    logic        rstN;
    logic        PSEL;
    logic        PENABLE;
    logic        PWRITE;
    logic [7:0]  PADDR;
    logic [31:0] PWDATA;
    logic [31:0] PRDATA;
    logic        PREADY;
    logic        PSLVERR;

    // model state
    logic [31:0] mReg [16];
    logic [3:0]  mFlags;
    logic [31:0] mRetired;

    logic [31:0] lfsr;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    int          testErrors = 0;
    int          tests = 0;
    int          failedTests = 0;

    aluExecTop #(
        .FIFO_DEPTH (DEPTH)
    ) u_aluExecTop (
        .clk     (clk),
        .rstN    (rstN),
        .PSEL    (PSEL),
        .PENABLE (PENABLE),
        .PWRITE  (PWRITE),
        .PADDR   (PADDR),
        .PWDATA  (PWDATA),
        .PRDATA  (PRDATA),
        .PREADY  (PREADY),
        .PSLVERR (PSLVERR)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // hard stop if the sequence stalls somewhere
    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("run stopped after %0d cycles without reaching the end", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one LFSR step per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsrNext(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [7:0] regAddr(input int idx);
        return aluPkg::ADDR_REG_BASE + 8'(4 * idx);
    endfunction

    function automatic logic condHolds(input logic [3:0] cond, input logic [3:0] fl);
        logic n;
        logic z;
        logic c;
        logic v;
        n = fl[3];
        z = fl[2];
        c = fl[1];
        v = fl[0];
        case (cond)
            aluPkg::AL: return 1'b1;
            aluPkg::EQ: return z;
            aluPkg::GT: return !z && (n == v);
            aluPkg::LT: return n != v;
            aluPkg::GE: return n == v;
            aluPkg::LE: return z || (n != v);
            aluPkg::HI: return c && !z;
            aluPkg::CC: return !c;
            aluPkg::CS: return c;
            default:    return 1'b0;
        endcase
    endfunction

    // reference behavior of one instruction applied in issue order
    task automatic modelExec(input logic [31:0] ins);
        logic [3:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        logic [31:0] res;
        logic [3:0]  f;
        logic        wr;
        logic        nz;
        longint      sres;
        op   = ins[27:24];
        a    = mReg[ins[19:16]];
        b    = mReg[ins[15:12]];
        sh   = ins[4:0];
        f    = mFlags;
        res  = '0;
        sres = 0;
        wr   = (op < 4'd12) && (op != aluPkg::CMP);
        nz   = (op < 4'd12) && (op != aluPkg::MOVI) && (op != aluPkg::MOV);
        case (op)
            aluPkg::ADD:
            begin
                res  = a + b;
                // unsigned wrap shows as a sum below an operand
                f[1] = (a + b) < a;
                sres = longint'($signed(a)) + longint'($signed(b));
                f[0] = sres != longint'($signed(res));
            end
            aluPkg::SUB, aluPkg::CMP:
            begin
                res  = a - b;
                f[1] = a >= b;
                sres = longint'($signed(a)) - longint'($signed(b));
                f[0] = sres != longint'($signed(res));
            end
            aluPkg::MUL:  res = a * b;
            aluPkg::OR:   res = a | b;
            aluPkg::AND:  res = a & b;
            aluPkg::XOR:  res = a ^ b;
            aluPkg::MOVI: res = {16'h0000, ins[15:0]};
            aluPkg::MOV:  res = b;
            aluPkg::LSR:
            begin
                res = b >> sh;
                if (sh != 0)
                    f[1] = b[sh - 1];
            end
            aluPkg::LSL:
            begin
                res = b << sh;
                if (sh != 0)
                    f[1] = b[32 - sh];
            end
            aluPkg::ROR:
            begin
                res = (sh == 0) ? b : ((b >> sh) | (b << (32 - sh)));
                if (sh != 0)
                    f[1] = res[31];
            end
            default:
            begin
                res = '0;
            end
        endcase
        if (nz)
        begin
            f[3] = res[31];
            f[2] = (res == 0);
        end
        if (condHolds(ins[31:28], mFlags))
        begin
            if (wr)
                mReg[ins[23:20]] = res;
            if (ins[11] || op == aluPkg::CMP)
                mFlags = f;
            if (op < 4'd12)
                mRetired = mRetired + 1;
        end
    endtask

    task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            $display("ERROR %s got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
            testErrors++;
        end
    endtask

    // tasks start and end 2 ns after a rising edge
    task automatic writeApb(input logic [7:0] addr, input logic [31:0] data);
        PSEL    = 1'b1;
        PENABLE = 1'b0;
        PWRITE  = 1'b1;
        PADDR   = addr;
        PWDATA  = data;
        @(posedge clk);
        #2;
        PENABLE = 1'b1;
        #1;
        // wait states until the completing edge
        while (!PREADY)
        begin
            @(posedge clk);
            #3;
        end
        checkVal("PSLVERR", {31'd0, PSLVERR}, 32'd0);
        @(posedge clk);
        #2;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
    endtask

    task automatic readApb(input logic [7:0] addr, output logic [31:0] data);
        PSEL    = 1'b1;
        PENABLE = 1'b0;
        PWRITE  = 1'b0;
        PADDR   = addr;
        @(posedge clk);
        #2;
        PENABLE = 1'b1;
        #1;
        // reads never insert wait states
        checkVal("PREADY", {31'd0, PREADY}, 32'd1);
        while (!PREADY)
        begin
            @(posedge clk);
            #3;
        end
        data = PRDATA;
        checkVal("PSLVERR", {31'd0, PSLVERR}, 32'd0);
        @(posedge clk);
        #2;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
    endtask

    task automatic loadReg(input int idx, input logic [31:0] val);
        writeApb(regAddr(idx), val);
        mReg[idx] = val;
    endtask

    task automatic writeFlags(input logic [3:0] fl);
        writeApb(aluPkg::ADDR_FLAGS, {28'd0, fl});
        mFlags = fl;
    endtask

    task automatic issueInstr(input logic [31:0] ins);
        writeApb(aluPkg::ADDR_INSTR, ins);
        modelExec(ins);
    endtask

    // poll STATUS until the FIFO count reads zero
    task automatic waitDrain();
        logic [31:0] st;
        int          polls;
        polls = 0;
        readApb(aluPkg::ADDR_STATUS, st);
        while (st[7:0] != 0 && polls < MAX_POLLS)
        begin
            polls++;
            readApb(aluPkg::ADDR_STATUS, st);
        end
        assert (st[7:0] == 0)
        else
        begin
            $display("FIFO still holds %0d entries after %0d status reads", st[7:0], polls);
            errors++;
            testErrors++;
        end
    endtask

    task automatic checkReg(input int idx);
        logic [31:0] got;
        readApb(regAddr(idx), got);
        checkVal($sformatf("r%0d", idx), got, mReg[idx]);
    endtask

    task automatic checkFlagsRetired();
        logic [31:0] got;
        readApb(aluPkg::ADDR_FLAGS, got);
        checkVal("FLAGS", got, {28'd0, mFlags});
        readApb(aluPkg::ADDR_RETIRED, got);
        checkVal("RETIRED", got, mRetired);
    endtask

    task automatic checkAll();
        for (int i = 0; i < 16; i++)
            checkReg(i);
        checkFlagsRetired();
    endtask

    // random instructions on r0..r3 so results feed later operands
    task automatic runBurst(input int n);
        logic [31:0] ins;
        for (int k = 0; k < n; k++)
        begin
            ins = randBits(32);
            ins[31:28] = randBits(1) ? 4'(aluPkg::AL) : 4'(randBits(4));
            ins[27:24] = 4'(randBits(4) % 12);
            ins[23:22] = 2'b00;
            ins[19:18] = 2'b00;
            ins[15:14] = 2'b00;
            issueInstr(ins);
        end
    endtask

    task automatic finishTest(input string group, input int idx);
        tests++;
        if (testErrors != 0)
            failedTests++;
        $display("%s %0d: %s", group, idx, (testErrors == 0) ? "passed" : "failed");
        testErrors = 0;
    endtask

    initial
    begin
        logic [31:0] ins;
        logic [31:0] got;
        logic [31:0] hostVal;
        logic [3:0]  hostFl;
        PSEL     = 1'b0;
        PENABLE  = 1'b0;
        PWRITE   = 1'b0;
        PADDR    = '0;
        PWDATA   = '0;
        rstN     = 1'b0;
        lfsr     = 32'hb4e1;
        mFlags   = '0;
        mRetired = '0;
        for (int i = 0; i < 16; i++)
            mReg[i] = '0;
        repeat (8) @(posedge clk);
        #2;
        rstN = 1'b1;

        // reset values
        readApb(aluPkg::ADDR_STATUS, got);
        checkVal("STATUS", got, 32'd0);
        checkAll();
        finishTest("reset", 0);

        // one AL instruction each with every opcode in the first twelve
        for (int i = 0; i < NUM_RANDOM; i++)
        begin
            ins = randBits(32);
            ins[31:28] = aluPkg::AL;
            ins[27:24] = (i < 12) ? 4'(i) : 4'(randBits(4) % 12);
            // same source now and then so SUB and XOR can reach zero
            if (randBits(2) == 0)
                ins[15:12] = ins[19:16];
            loadReg(ins[19:16], randBits(32));
            loadReg(ins[15:12], randBits(32));
            issueInstr(ins);
            waitDrain();
            checkReg(ins[23:20]);
            checkFlagsRetired();
            finishTest("random", i);
        end

        // condition field against host loaded flags
        for (int i = 0; i < NUM_COND; i++)
        begin
            writeFlags(4'(randBits(4)));
            ins = randBits(32);
            ins[31:28] = 4'(randBits(4));
            ins[27:24] = aluPkg::ADD;
            issueInstr(ins);
            waitDrain();
            checkReg(ins[23:20]);
            checkFlagsRetired();
            finishTest("cond", i);
        end

        // back to back dependent stream
        runBurst(BURST_LEN);
        waitDrain();
        checkAll();
        finishTest("burst", 0);

        // host writes queued behind a burst must land after its last entry
        runBurst(DEPTH);
        ins = randBits(32);
        ins[31:28] = aluPkg::AL;
        ins[27:24] = aluPkg::ADD;
        ins[23:20] = 4'd7;
        ins[11]    = 1'b1;
        issueInstr(ins);
        hostVal = randBits(32);
        hostFl  = 4'(randBits(4));
        loadReg(7, hostVal);
        writeFlags(hostFl);
        readApb(regAddr(7), got);
        checkVal("r7", got, hostVal);
        readApb(aluPkg::ADDR_FLAGS, got);
        checkVal("FLAGS", got, {28'd0, hostFl});
        checkAll();
        finishTest("hostwrite", 0);

        // memory group executes as a no-op
        for (int i = 12; i < 16; i++)
        begin
            ins = randBits(32);
            ins[31:28] = aluPkg::AL;
            ins[27:24] = 4'(i);
            ins[11]    = 1'b1;
            issueInstr(ins);
            waitDrain();
            checkAll();
            finishTest("reserved", i);
        end

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, failedTests, checks, errors);
        if (errors == 0 && failedTests == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
aluPkg.sv
regAccessIf.sv
apbIssue.sv
opFifo.sv
regFile.sv
aluCore.sv
execUnit.sv
aluExecTop.sv
aluExecTop_props.sv
aluExecTb.sv

//--- run.sh
#!/bin/sh
# build and run the execute subsystem testbench, pass only on the pass line
verilator --binary --timing --assert -Wno-fatal --top-module aluExecTb -f src.f -o aluExecSim \
    && ./obj_dir/aluExecSim | tee /dev/stderr | grep -qx "Test OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
